// File: gauss_blur.f
design/blur_pkg.sv
design/blur_ifs.sv
design/strip_sequencer.sv
design/gauss3_engine.sv
design/gauss5_engine.sv
design/strip_writeback.sv
design/gauss_blur_top.sv
verification/gauss_blur_chk.sv
verification/gauss_blur_tb.sv

// File: Bender.yml
package:
  name: gauss_blur

sources:
  - design/blur_pkg.sv
  - design/blur_ifs.sv
  - design/strip_sequencer.sv
  - design/gauss3_engine.sv
  - design/gauss5_engine.sv
  - design/strip_writeback.sv
  - design/gauss_blur_top.sv
  - target: test
    files:
      - verification/gauss_blur_chk.sv
      - verification/gauss_blur_tb.sv

// File: verification/gauss_blur_tb.sv
`timescale 1ns/1ps

module gauss_blur_tb;
  import blur_pkg::*;

  localparam int IMG_ROWS   = 8;
  localparam int N_RUNS     = 3;
  localparam int WRITES     = STRIPS * IMG_ROWS;
  localparam int MAX_CYCLES = N_RUNS * (2 * STRIPS * (IMG_ROWS + 4) + 20) + 20;

  logic                clk;
  logic                rst_n;
  logic                start;
  logic                done;
  logic                blur_we;
  logic [ROW_W-1:0]    img_addr;
  logic [ROW_W-1:0]    blur_addr;
  logic [ROW_BITS-1:0] img_dout;
  logic [ROW_BITS-1:0] blur3_dout;
  logic [ROW_BITS-1:0] blur5_dout;
  logic [ROW_BITS-1:0] blur3_din;
  logic [ROW_BITS-1:0] blur5_din;

  logic [ROW_BITS-1:0] img_mem [2**ROW_W];
  logic [ROW_BITS-1:0] mem3 [2**ROW_W];
  logic [ROW_BITS-1:0] mem5 [2**ROW_W];
  integer              seed;
  int                  cycles = 0;
  int                  wr_total = 0;
  int                  rises = 0;
  logic                done_q = 1'b0;

  gauss_blur_top #(
    .IMG_ROWS (IMG_ROWS)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .done       (done),
    .img_addr   (img_addr),
    .img_dout   (img_dout),
    .blur_addr  (blur_addr),
    .blur3_dout (blur3_dout),
    .blur5_dout (blur5_dout),
    .blur_we    (blur_we),
    .blur3_din  (blur3_din),
    .blur5_din  (blur5_din)
  );

  bind gauss_blur_top gauss_blur_chk i_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .done    (done),
    .blur_we (blur_we)
  );

  // combinational reads, clocked write
  assign img_dout   = img_mem[img_addr];
  assign blur3_dout = mem3[blur_addr];
  assign blur5_dout = mem5[blur_addr];

  always @(posedge clk) begin
    if (blur_we) begin
      mem3[blur_addr] <= blur3_din;
      mem5[blur_addr] <= blur5_din;
    end
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic expect_eq(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // binomial taps, 1-2-1 or 1-4-6-4-1
  function automatic int tap_weight(input int size, input int i);
    if (size == 3) begin
      return (i == 1) ? 2 : 1;
    end
    return (i == 2) ? 6 : ((i == 1 || i == 3) ? 4 : 1);
  endfunction

  // one blurred pixel, zeros outside the image
  function automatic int blur_ref(input int r, input int c, input int size);
    int h;
    int sh;
    int acc;
    int rr;
    int cc;
    h   = size / 2;
    sh  = (size == 3) ? 4 : 8;
    acc = 0;
    for (int dy = 0; dy < size; dy++) begin
      for (int dx = 0; dx < size; dx++) begin
        rr = r + dy - h;
        cc = c + dx - h;
        if (rr >= 0 && rr < IMG_ROWS && cc >= 0 && cc < IMG_W) begin
          acc += tap_weight(size, dy) * tap_weight(size, dx)
               * int'(img_mem[rr][cc*PIX_W +: PIX_W]);
        end
      end
    end
    return (acc + (1 << (sh - 1))) >> sh;
  endfunction

  function automatic strip_t ref_strip(input int r, input int s, input int size);
    strip_t v;
    for (int l = 0; l < LANES; l++) begin
      v[l] = PIX_W'(blur_ref(r, s * LANES + l, size));
    end
    return v;
  endfunction

  task automatic load_random_image();
    for (int r = 0; r < 2**ROW_W; r++) begin
      img_mem[r] = '0;
      for (int w = 0; w < ROW_BITS / 32; w++) begin
        if (r < IMG_ROWS) begin
          img_mem[r][w*32 +: 32] = $random(seed);
        end
      end
    end
  endtask

  task automatic load_flat_image(input int value);
    for (int r = 0; r < 2**ROW_W; r++) begin
      img_mem[r] = (r < IMG_ROWS) ? {IMG_W{PIX_W'(value)}} : '0;
    end
  endtask

  // marker depends on row and pixel position
  task automatic preload_markers();
    for (int a = 0; a < 2**ROW_W; a++) begin
      for (int p = 0; p < IMG_W; p++) begin
        mem3[a][p*PIX_W +: PIX_W] = PIX_W'(a * 16 + p) ^ 8'h3c;
        mem5[a][p*PIX_W +: PIX_W] = PIX_W'(a * 16 + p) ^ 8'hc3;
      end
    end
  endtask

  // writes come strip by strip, rows in order
  always @(negedge clk) begin
    int idx;
    int s;
    int r;
    if (rst_n && blur_we) begin
      idx = wr_total % WRITES;
      s   = idx / IMG_ROWS;
      r   = idx % IMG_ROWS;
      expect_eq("blur_addr", blur_addr, r);
      for (int k = 0; k < STRIPS; k++) begin
        if (k == s) begin
          expect_eq($sformatf("blur3_din slot %0d", k), blur3_din[k*32 +: 32],
                    ref_strip(r, s, 3));
          expect_eq($sformatf("blur5_din slot %0d", k), blur5_din[k*32 +: 32],
                    ref_strip(r, s, 5));
        end else begin
          expect_eq($sformatf("blur3_din slot %0d", k), blur3_din[k*32 +: 32],
                    mem3[r][k*32 +: 32]);
          expect_eq($sformatf("blur5_din slot %0d", k), blur5_din[k*32 +: 32],
                    mem5[r][k*32 +: 32]);
        end
      end
      wr_total++;
    end
    if (done && !done_q) begin
      rises++;
    end
    done_q <= done;
  end

  // a bound checker failure ends the run right away
  always @(negedge clk) begin
    if (i_dut.i_chk.err_seen) begin
      $display("A bound assertion on the handshake or write timing failed");
      $display("TEST FAILED");
      $fatal(1, "bound assertion fired");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the runs did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic run_blur(input int run);
    @(negedge clk);
    start = 1'b1;
    while (!done) begin
      @(negedge clk);
    end
    expect_eq("write count", wr_total, run * WRITES);
    // ack must hold while req is still high
    repeat (3) begin
      @(negedge clk);
      expect_eq("done", done, 1'b1);
    end
    expect_eq("done rise count", rises, run);
    start = 1'b0;
    // ack drops the cycle after req is seen low
    @(negedge clk);
    expect_eq("done", done, 1'b0);
  endtask

  task automatic compare_memories();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        expect_eq($sformatf("blur3[%0d][%0d]", r, c), mem3[r][c*PIX_W +: PIX_W],
                  blur_ref(r, c, 3));
        expect_eq($sformatf("blur5[%0d][%0d]", r, c), mem5[r][c*PIX_W +: PIX_W],
                  blur_ref(r, c, 5));
      end
    end
  endtask

  task automatic verify_flat_interior(input int value);
    for (int r = 1; r < IMG_ROWS - 1; r++) begin
      for (int c = 1; c < IMG_W - 1; c++) begin
        expect_eq($sformatf("blur3[%0d][%0d]", r, c), mem3[r][c*PIX_W +: PIX_W], value);
        if (r >= 2 && r < IMG_ROWS - 2 && c >= 2 && c < IMG_W - 2) begin
          expect_eq($sformatf("blur5[%0d][%0d]", r, c), mem5[r][c*PIX_W +: PIX_W], value);
        end
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    seed  = 81;
    load_random_image();
    preload_markers();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // idle with start low
    repeat (5) begin
      @(negedge clk);
      expect_eq("done", done, 1'b0);
      expect_eq("blur_we", blur_we, 1'b0);
    end
    run_blur(1);
    compare_memories();
    load_random_image();
    preload_markers();
    run_blur(2);
    compare_memories();
    load_flat_image(200);
    preload_markers();
    run_blur(3);
    compare_memories();
    verify_flat_interior(200);
    repeat (2) @(negedge clk);
    if (i_dut.i_chk.err_seen) begin
      $display("TEST FAILED");
      $fatal(1, "bound assertion fired");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: verification/gauss_blur_chk.sv
`timescale 1ns/1ps

module gauss_blur_chk (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic done,
  input logic blur_we
);

  // set once any property below fails
  logic err_seen;

  initial err_seen = 1'b0;

  // ack only rises under an active req
  a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> start)
    else begin
      $error("done rose while start was low");
      err_seen = 1'b1;
    end

  // ack released only after req has dropped
  a_done_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(done) |-> !$past(start))
    else begin
      $error("done fell while start was still high");
      err_seen = 1'b1;
    end

  // all writes finish before the ack
  a_no_write_done: assert property (@(posedge clk) disable iff (!rst_n)
    !(blur_we && done))
    else begin
      $error("blur_we high while done high");
      err_seen = 1'b1;
    end

endmodule

// File: design/gauss_blur_top.sv
`timescale 1ns/1ps

module gauss_blur_top #(
  parameter int IMG_ROWS = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  output logic                          done,
  output logic [blur_pkg::ROW_W-1:0]    img_addr,
  input  logic [blur_pkg::ROW_BITS-1:0] img_dout,
  output logic [blur_pkg::ROW_W-1:0]    blur_addr,
  input  logic [blur_pkg::ROW_BITS-1:0] blur3_dout,
  input  logic [blur_pkg::ROW_BITS-1:0] blur5_dout,
  output logic                          blur_we,
  output logic [blur_pkg::ROW_BITS-1:0] blur3_din,
  output logic [blur_pkg::ROW_BITS-1:0] blur5_din
);

  row_stream_if rows_if ();
  kernel_res_if res3_if ();
  kernel_res_if res5_if ();

  strip_sequencer #(
    .IMG_ROWS (IMG_ROWS)
  ) u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .img_addr (img_addr),
    .img_dout (img_dout),
    .rows     (rows_if.src)
  );

  // both kernels see the same row stream
  gauss3_engine u_g3 (
    .clk   (clk),
    .rst_n (rst_n),
    .rows  (rows_if.sink),
    .res   (res3_if.src)
  );

  gauss5_engine u_g5 (
    .clk   (clk),
    .rst_n (rst_n),
    .rows  (rows_if.sink),
    .res   (res5_if.src)
  );

  strip_writeback #(
    .IMG_ROWS (IMG_ROWS)
  ) u_wb (
    .clk        (clk),
    .rst_n      (rst_n),
    .res3       (res3_if.sink),
    .res5       (res5_if.sink),
    .blur_addr  (blur_addr),
    .blur3_dout (blur3_dout),
    .blur5_dout (blur5_dout),
    .blur_we    (blur_we),
    .blur3_din  (blur3_din),
    .blur5_din  (blur5_din)
  );

endmodule

// File: design/strip_writeback.sv
`timescale 1ns/1ps

module strip_writeback #(
  parameter int IMG_ROWS = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  kernel_res_if.sink                 res3,
  kernel_res_if.sink                 res5,
  output logic [blur_pkg::ROW_W-1:0] blur_addr,
  input  blur_pkg::row_word_u        blur3_dout,
  input  blur_pkg::row_word_u        blur5_dout,
  output logic                       blur_we,
  output blur_pkg::row_word_u        blur3_din,
  output blur_pkg::row_word_u        blur5_din
);
  import blur_pkg::*;

  logic               pair_ok;
  logic               row_ok;
  logic [ROW_W-1:0]   wr_row;
  logic [STRIP_W-1:0] wr_strip;
  strip_t             wr_pix3;
  strip_t             wr_pix5;

  // both engines must agree on row and strip
  assign pair_ok = res3.valid && res5.valid
                && (res3.row == res5.row)
                && (res3.strip == res5.strip);

  // drop rows past the image bottom
  assign row_ok = int'(res3.row) < IMG_ROWS;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we <= 1'b0;
    end else begin
      blur_we <= pair_ok && row_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (pair_ok) begin
      wr_row   <= res3.row;
      wr_strip <= res3.strip;
      wr_pix3  <= res3.pix;
      wr_pix5  <= res5.pix;
    end
  end

  // read and write share one address, both in the write cycle
  assign blur_addr = wr_row;

  // keep the other slots, replace only this strip
  always_comb begin
    blur3_din = blur3_dout;
    blur5_din = blur5_dout;
    blur3_din.slot[wr_strip] = wr_pix3;
    blur5_din.slot[wr_strip] = wr_pix5;
  end

endmodule

// File: design/gauss5_engine.sv
`timescale 1ns/1ps

module gauss5_engine (
  input  logic       clk,
  input  logic       rst_n,
  row_stream_if.sink rows,
  kernel_res_if.src  res
);
  import blur_pkg::*;

  localparam int TAPS  = 5;
  localparam int LAG   = 2 * HALO;
  localparam int CNT_W = ROW_W + 1;

  halo_row_t        win [TAPS];
  logic [CNT_W-1:0] beat_cnt;
  // 16 x 255 fits in 12 bits
  logic [11:0]      vsum [WIN_W];
  // 256 x 255 fits in 16 bits
  logic [15:0]      hsum [LANES];

  // shift register of rows, newest at index 0
  always_ff @(posedge clk) begin
    if (rows.valid) begin
      win[0] <= rows.row;
      for (int i = 1; i < TAPS; i++) begin
        win[i] <= rows.first ? '0 : win[i-1];
      end
    end
  end

  // four beats after first the window is full and centred on row 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt  <= '0;
      res.valid <= 1'b0;
    end else begin
      res.valid <= rows.valid && !rows.first && (beat_cnt >= CNT_W'(LAG));
      if (rows.valid) begin
        beat_cnt <= rows.first ? CNT_W'(1) : beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rows.valid) begin
      res.row   <= ROW_W'(beat_cnt - CNT_W'(LAG));
      res.strip <= rows.strip;
    end
  end

  // vertical pass over every halo column
  always_comb begin
    for (int k = 0; k < WIN_W; k++) begin
      vsum[k] = 12'(win[4][k])
              + (12'(win[3][k]) << 2)
              + 12'(win[2][k]) * 12'd6
              + (12'(win[1][k]) << 2)
              + 12'(win[0][k]);
    end
  end

  // horizontal pass per lane
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      hsum[l] = 16'(vsum[l])
              + (16'(vsum[l+1]) << 2)
              + 16'(vsum[l+2]) * 16'd6
              + (16'(vsum[l+3]) << 2)
              + 16'(vsum[l+4]);
      // divide by 256, round half up
      res.pix[l] = PIX_W'((hsum[l] + 16'd128) >> 8);
    end
  end

endmodule

// File: design/gauss3_engine.sv
`timescale 1ns/1ps

module gauss3_engine (
  input  logic       clk,
  input  logic       rst_n,
  row_stream_if.sink rows,
  kernel_res_if.src  res
);
  import blur_pkg::*;

  // one extra row so the centre lines up with the 5x5 engine
  localparam int TAPS  = 4;
  localparam int LAG   = 2 * HALO;
  localparam int CNT_W = ROW_W + 1;

  halo_row_t        win [TAPS];
  logic [CNT_W-1:0] beat_cnt;
  // column sums, entry j is halo column j+1
  logic [9:0]       vsum [LANES+2];
  logic [11:0]      hsum [LANES];

  // newest row at index 0, centre at index 2
  always_ff @(posedge clk) begin
    if (rows.valid) begin
      win[0] <= rows.row;
      for (int i = 1; i < TAPS; i++) begin
        win[i] <= rows.first ? '0 : win[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt  <= '0;
      res.valid <= 1'b0;
    end else begin
      res.valid <= rows.valid && !rows.first && (beat_cnt >= CNT_W'(LAG));
      if (rows.valid) begin
        beat_cnt <= rows.first ? CNT_W'(1) : beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rows.valid) begin
      res.row   <= ROW_W'(beat_cnt - CNT_W'(LAG));
      res.strip <= rows.strip;
    end
  end

  // 1-2-1 down the columns, then across
  always_comb begin
    for (int j = 0; j < LANES + 2; j++) begin
      vsum[j] = 10'(win[3][j+1]) + (10'(win[2][j+1]) << 1) + 10'(win[1][j+1]);
    end
    for (int l = 0; l < LANES; l++) begin
      hsum[l] = 12'(vsum[l]) + (12'(vsum[l+1]) << 1) + 12'(vsum[l+2]);
      // divide by 16, round half up
      res.pix[l] = PIX_W'((hsum[l] + 12'd8) >> 4);
    end
  end

endmodule

// File: design/strip_sequencer.sv
`timescale 1ns/1ps

module strip_sequencer #(
  parameter int IMG_ROWS = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  output logic                       done,
  output logic [blur_pkg::ROW_W-1:0] img_addr,
  input  blur_pkg::row_word_u        img_dout,
  row_stream_if.src                  rows
);
  import blur_pkg::*;

  // two zero rows above and below every strip
  localparam int BEATS = IMG_ROWS + 2 * HALO;
  localparam int CNT_W = $clog2(BEATS);
  // engine stage plus write-back stage, then two cycles to ack
  localparam int DRAIN = 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_FINISH
  } state_t;

  state_t             state;
  logic [CNT_W-1:0]   row_cnt;
  logic [STRIP_W-1:0] strip_cnt;
  logic [1:0]         drain_cnt;
  logic               last_beat;
  logic               in_image;
  halo_row_t          halo;

  // row_cnt 0 is padded row -2
  assign last_beat = (row_cnt == CNT_W'(BEATS - 1));
  assign in_image  = (row_cnt >= CNT_W'(HALO)) && (row_cnt < CNT_W'(IMG_ROWS + HALO));
  assign img_addr  = in_image ? ROW_W'(row_cnt - CNT_W'(HALO)) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      row_cnt   <= '0;
      strip_cnt <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          row_cnt   <= '0;
          strip_cnt <= '0;
          if (start) begin
            state <= ST_STREAM;
          end
        end
        ST_STREAM: begin
          if (last_beat) begin
            row_cnt <= '0;
            // next strip follows with no gap
            if (strip_cnt == STRIP_W'(STRIPS - 1)) begin
              strip_cnt <= '0;
              drain_cnt <= '0;
              state     <= ST_FINISH;
            end else begin
              strip_cnt <= strip_cnt + 1'b1;
            end
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        ST_FINISH: begin
          if (!done) begin
            if (drain_cnt == 2'(DRAIN)) begin
              done <= 1'b1;
            end else begin
              drain_cnt <= drain_cnt + 1'b1;
            end
          end else if (!start) begin
            // req dropped, release the ack
            done  <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // strip plus halo, zero outside the image
  always_comb begin
    int col;
    halo = '0;
    for (int k = 0; k < WIN_W; k++) begin
      col = int'(strip_cnt) * LANES - HALO + k;
      if (in_image && col >= 0 && col < IMG_W) begin
        halo[k] = img_dout.flat[col*PIX_W +: PIX_W];
      end
    end
  end

  assign rows.valid = (state == ST_STREAM);
  assign rows.first = (state == ST_STREAM) && (row_cnt == '0);
  assign rows.row   = halo;
  assign rows.strip = strip_cnt;

endmodule

// File: design/blur_ifs.sv
`timescale 1ns/1ps

// one padded image row per beat, strip with halo
interface row_stream_if;
  import blur_pkg::*;

  logic                 valid;
  halo_row_t            row;
  logic [STRIP_W-1:0]   strip;
  // padded row -2, start of a strip
  logic                 first;

  modport src (output valid, row, strip, first);
  modport sink (input valid, row, strip, first);

endinterface

// one blurred strip for one centre row
interface kernel_res_if;
  import blur_pkg::*;

  logic                 valid;
  strip_t               pix;
  logic [ROW_W-1:0]     row;
  logic [STRIP_W-1:0]   strip;

  modport src (output valid, pix, row, strip);
  modport sink (input valid, pix, row, strip);

endinterface

// File: design/blur_pkg.sv
package blur_pkg;

  // pixel and strip geometry
  localparam int PIX_W   = 8;
  localparam int LANES   = 4;
  localparam int STRIPS  = 4;
  localparam int HALO    = 2;

  // image width in pixels
  localparam int IMG_W   = LANES * STRIPS;

  // strip plus neighbours on both sides
  localparam int WIN_W   = LANES + 2 * HALO;

  // one memory row, all strips side by side
  localparam int ROW_BITS = IMG_W * PIX_W;

  // row address and strip index widths
  localparam int ROW_W   = 4;
  localparam int STRIP_W = $clog2(STRIPS);

  typedef logic [PIX_W-1:0] pix_t;

  // lane 0 is the leftmost pixel of the strip
  typedef pix_t [LANES-1:0] strip_t;

  // index 0 is the leftmost halo pixel
  typedef pix_t [WIN_W-1:0] halo_row_t;

  // one image or blur row, seen as pixels or as strip slots
  // slot 0 sits in the low bits and holds the leftmost strip
  typedef union packed {
    logic [ROW_BITS-1:0]    flat;
    strip_t [STRIPS-1:0]    slot;
  } row_word_u;

endpackage
